/* frogger.f */
verilog/frogger_pkg.sv
verilog/scene_if.sv
verilog/scene_regs.sv
verilog/row_hit.sv
verilog/scenery_map.sv
verilog/scene_render.sv
verilog/color_mapper.sv
verification/color_mapper_chk.sv
verification/tb_color_mapper.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal -j 0
TOP       = tb_color_mapper
FILELIST  = frogger.f
OBJ_DIR   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* verification/tb_color_mapper.sv */
// directed tests only; no pixels are streamed while a register write is in flight
module tb_color_mapper;
	import frogger_pkg::*;

	localparam int num_ops = 700; // rough count of bus and pixel operations

	logic clk = 0, rst = 1;
	logic awvalid = 0, wvalid = 0, bready = 1, arvalid = 0, rready = 1;
	logic awready, wready, bvalid, arready, rvalid, rgb_valid;
	logic [7:0] awaddr = 0, araddr = 0;
	logic [31:0] wdata = 0, rdata;
	logic [3:0] wstrb = 0;
	logic [1:0] bresp, rresp;
	logic draw_valid = 0;
	logic [coord_w-1:0] draw_x = 0, draw_y = 0;
	logic [color_w-1:0] red, green, blue;

	logic [31:0] shadow [64]; // expected register contents by word index
	logic [31:0] rng = 32'd1671;
	logic checking = 0;
	logic e1_v = 0, e2_v = 0;
	logic [23:0] e1_c, e2_c;

	color_mapper color_mapper_i (.*);

	initial
	begin
		forever #20 clk = ~clk;
	end

	initial
	begin
		#(num_ops * 20 * 40);
		$display("watchdog expired, the tests did not finish in time");
		fail_now();
	end

	task automatic fail_now();
		$display("TEST FAILED");
		$fatal(1, "run stopped");
	endtask

	function automatic logic [31:0] xorshift();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	// ------------------------------
	// compare tasks
	// ------------------------------
	task automatic check_rgb(input logic [color_w-1:0] r, g, b, input logic [23:0] exp);
		if ({r, g, b} !== exp)
		begin
			$display("FAIL %0t: rgb %h expected %h", $time, {r, g, b}, exp);
			fail_now();
		end
	endtask

	task automatic check_word(input scene_word_u got, input scene_word_u exp);
		if (got !== exp)
		begin
			$display("FAIL %0t: read data %h expected %h", $time, got, exp);
			fail_now();
		end
	endtask

	task automatic check_resp(input logic [1:0] got, input logic [1:0] exp);
		if (got !== exp)
		begin
			$display("FAIL %0t: response %b expected %b", $time, got, exp);
			fail_now();
		end
	endtask

	task automatic check_valid(input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("FAIL %0t: valid %b expected %b", $time, got, exp);
			fail_now();
		end
	endtask

	// ------------------------------
	// reference model
	// ------------------------------
	function automatic logic [31:0] word_mask(input int i);
		if (i < 3 || (i >= 16 && i < 48))
			return 32'h07FF07FF; // x and y fields
		else if (i == 3)
			return 32'h00FFFFFF;
		return 32'h0;
	endfunction

	function automatic logic [23:0] scenery_rgb(input int x, input int y);
		logic goal;
		goal = y >= 40 && y <= 79;
		if (y >= 80 && y <= 239)
			return {8'd0, 8'd200, 8'd255};
		if (goal && (x <= 119 || (x >= 160 && x <= 279) || (x >= 320 && x <= 479)
			|| (x >= 520 && x <= 679)))
			return {8'd0, 8'd100, 8'd0};
		if ((y >= 240 && y <= 279) || y >= 440 || (goal && x <= 519))
			return {8'd0, 8'd200, 8'd0}; // goal gaps are the x left below 520
		if (((y >= 318 && y <= 322) || (y >= 358 && y <= 362) || (y >= 398 && y <= 402))
			&& (x <= 100 || (x >= 200 && x <= 300) || (x >= 400 && x <= 500) || x >= 600))
			return {8'd255, 8'd204, 8'd0};
		if (y >= 280 && y <= 439)
			return {8'd69, 8'd69, 8'd69};
		return {8'd255, 8'd255, 8'd255};
	endfunction

	function automatic logic row_covers(input int base, input int cnt, input int w,
		input int x, input int y);
		int ox, oy, l;
		for (int s = 0; s < cnt && s < 4; s++)
		begin
			ox = shadow[base + s][10:0];
			oy = shadow[base + s][26:16];
			l = (ox >= 680) ? 0 : ox;
			if (x >= l && x <= (ox + w) % 2048 && y >= oy && y <= (oy + 40) % 2048)
				return 1;
		end
		return 0;
	endfunction

	function automatic logic [23:0] expected_rgb(input int x, input int y);
		int fx, fy;
		logic car, pad;
		for (int f = 0; f < 3; f++)
		begin
			fx = shadow[f][10:0];
			fy = shadow[f][26:16];
			if (x >= (fx + 7) % 2048 && x <= (fx + 33) % 2048 &&
				y >= (fy + 10) % 2048 && y <= (fy + 35) % 2048)
				return {8'd40, 8'd160, 8'd40};
		end
		car = 0;
		pad = 0;
		for (int r = 0; r < 4; r++)
		begin
			car |= row_covers(16 + 4 * r, int'((shadow[3] >> (3 * r)) & 7), 80, x, y);
			pad |= row_covers(32 + 4 * r, int'((shadow[3] >> (12 + 3 * r)) & 7), 40, x, y);
		end
		if (car)
			return {8'd200, 8'd0, 8'd0};
		if (pad)
			return {8'd0, 8'd250, 8'd0};
		return scenery_rgb(x, y);
	endfunction

	// inputs are stable at the falling edge; outputs seen here belong to two falls ago
	always @(negedge clk)
	begin
		if (checking)
		begin
			check_valid(rgb_valid, e2_v);
			if (e2_v)
				check_rgb(red, green, blue, e2_c);
			e2_v = e1_v;
			e2_c = e1_c;
			e1_v = draw_valid;
			e1_c = expected_rgb(draw_x, draw_y);
		end
	end

	// ------------------------------
	// bus and pixel drivers
	// ------------------------------
	task automatic axi_write(input logic [7:0] a, input logic [31:0] d, input logic [3:0] s);
		logic [31:0] bm;
		@(posedge clk);
		awvalid <= 1;
		wvalid  <= 1;
		awaddr  <= a;
		wdata   <= d;
		wstrb   <= s;
		bready  <= 0;
		@(negedge clk);
		while (!awready)
			@(negedge clk);
		check_valid(wready, 1'b1); // taken together with the address
		@(posedge clk);
		awvalid <= 0;
		wvalid  <= 0;
		@(negedge clk);
		while (!bvalid)
			@(negedge clk);
		check_resp(bresp, word_mask(a >> 2) != 0 ? 2'b00 : 2'b10);
		@(negedge clk);
		check_valid(bvalid, 1'b1); // held while bready is low
		@(posedge clk);
		bready <= 1;
		bm = {{8{s[3]}}, {8{s[2]}}, {8{s[1]}}, {8{s[0]}}};
		shadow[a >> 2] = ((shadow[a >> 2] & ~bm) | (d & bm)) & word_mask(a >> 2);
	endtask

	task automatic axi_read(input logic [7:0] a, input int stall);
		@(posedge clk);
		arvalid <= 1;
		araddr  <= a;
		rready  <= (stall == 0);
		@(negedge clk);
		while (!arready)
			@(negedge clk);
		@(posedge clk);
		arvalid <= 0;
		@(negedge clk);
		while (!rvalid)
			@(negedge clk);
		check_word(rdata, shadow[a >> 2]);
		check_resp(rresp, word_mask(a >> 2) != 0 ? 2'b00 : 2'b10);
		repeat (stall)
			@(negedge clk);
		check_valid(rvalid, 1'b1); // held while rready is low
		@(posedge clk);
		rready <= 1;
	endtask

	task automatic set_pos(input int idx, input int x, input int y);
		scene_word_u w;
		w = '0;
		w.pos.x = x;
		w.pos.y = y;
		axi_write(8'(idx * 4), w, 4'hF);
	endtask

	task automatic pixel(input int x, input int y);
		@(posedge clk);
		draw_valid <= 1;
		draw_x <= x;
		draw_y <= y;
	endtask

	task automatic drain();
		@(posedge clk);
		draw_valid <= 0;
		repeat (3)
			@(posedge clk);
	endtask

	// ------------------------------
	// tests
	// ------------------------------
	task automatic test_registers();
		for (int i = 0; i < 48; i++)
		begin
			if (word_mask(i) != 0)
			begin
				axi_write(8'(i * 4), xorshift(), 4'(xorshift()));
				axi_read(8'(i * 4), i % 3);
			end
		end
		axi_write(8'h10, 32'hFFFF_FFFF, 4'hF);
		axi_read(8'h10, 0);
		axi_write(8'hC4, 32'h1234_5678, 4'hF);
		axi_read(8'hC4, 2);
		axi_write(8'h0C, 32'h0, 4'hF); // all counts zero
		for (int f = 0; f < 3; f++)
			set_pos(f, 2000, 2000); // frogs parked off screen
	endtask

	task automatic test_scenery();
		int pts [20] = '{300, 100, 50, 60, 140, 60, 300, 250, 300, 460,
			50, 320, 150, 320, 300, 20, 690, 60, 620, 400};
		for (int i = 0; i < 20; i += 2)
			pixel(pts[i], pts[i + 1]);
		drain();
	endtask

	task automatic test_frog();
		int pts [20] = '{207, 310, 233, 310, 207, 335, 233, 335, 206, 310,
			234, 320, 220, 309, 220, 336, 230, 332, 250, 350};
		set_pos(0, 200, 300);
		set_pos(16, 225, 330); // car under the lower right of the frog
		axi_write(8'h0C, 32'h1, 4'hF);
		for (int i = 0; i < 20; i += 2)
			pixel(pts[i], pts[i + 1]);
		drain();
		set_pos(0, 2000, 2000);
	endtask

	task automatic test_cars();
		int pts [14] = '{0, 360, 32, 360, 33, 360, 420, 320, 340, 220, 390, 245, 410, 250};
		set_pos(20, 300, 200);
		set_pos(21, 2000, 350); // wraps to columns 0..32
		set_pos(22, 400, 300);  // slot at the count, hidden
		set_pos(24, 330, 210);  // row 3 overlapping row 2
		axi_write(8'h0C, 32'h0000_0050, 4'hF);
		for (int i = 0; i < 14; i += 2)
			pixel(pts[i], pts[i + 1]);
		drain();
	endtask

	task automatic test_pads();
		int pts [12] = '{100, 120, 105, 125, 140, 160, 141, 150, 150, 140, 190, 170};
		set_pos(32, 100, 120);
		set_pos(28, 110, 130); // car row 4 across the pad
		axi_write(8'h0C, 32'h0000_1200, 4'hF);
		for (int i = 0; i < 12; i += 2)
			pixel(pts[i], pts[i + 1]);
		drain();
	endtask

	task automatic test_stream();
		for (int i = 0; i < 3; i++)
			set_pos(i, xorshift() % 700, xorshift() % 480);
		for (int i = 16; i < 48; i++)
			set_pos(i, xorshift() % 2048, xorshift() % 480);
		axi_write(8'h0C, xorshift(), 4'hF);
		for (int i = 0; i < 300; i++)
			pixel(xorshift() % 800, xorshift() % 480);
		drain();
	endtask

	initial
	begin
		for (int i = 0; i < 64; i++)
			shadow[i] = '0;
		repeat (5)
			@(posedge clk);
		rst <= 0;
		@(negedge clk);
		checking = 1;
		test_registers();
		test_scenery();
		test_frog();
		test_cars();
		test_pads();
		test_stream();
		$display("TEST OK");
		$finish;
	end

endmodule

/* verification/color_mapper_chk.sv */
// generic valid checker; bound once on the pixel pipeline and once per AXI response channel
module color_mapper_chk (
	input logic clk,
	input logic rst,
	input logic in_valid,   // pipeline input valid
	input logic out_valid,  // same valid two stages later
	input logic hold_valid, // response valid that must wait for ready
	input logic hold_ready
);

	// ------------------------------
	// pipeline latency
	// ------------------------------
	assert property (@(posedge clk) disable iff (rst)
		(!$past(rst) && !$past(rst, 2)) |-> out_valid == $past(in_valid, 2))
		else $error("output valid does not follow input valid by two cycles");

	// response stays up until taken
	assert property (@(posedge clk) disable iff (rst)
		hold_valid && !hold_ready |=> hold_valid)
		else $error("response valid dropped before ready");

	assert property (@(posedge clk) rst |=> !hold_valid && !out_valid)
		else $error("valid high in the cycle after reset");

endmodule

bind scene_render color_mapper_chk pipe_chk (
	.clk(clk), .rst(rst), .in_valid(draw_valid), .out_valid(rgb_valid),
	.hold_valid(1'b0), .hold_ready(1'b1)
);

bind scene_regs color_mapper_chk b_chk (
	.clk(clk), .rst(rst), .in_valid(1'b0), .out_valid(1'b0),
	.hold_valid(bvalid), .hold_ready(bready)
);

bind scene_regs color_mapper_chk r_chk (
	.clk(clk), .rst(rst), .in_valid(1'b0), .out_valid(1'b0),
	.hold_valid(rvalid), .hold_ready(rready)
);

/* verilog/color_mapper.sv */
// AXI4-Lite scene registers in front of a 2-cycle pixel colour pipeline; single clock domain
module color_mapper
	import frogger_pkg::*;
(
	input  logic                clk,
	input  logic                rst,
	input  logic                awvalid,
	output logic                awready,
	input  logic [addr_w-1:0]   awaddr,
	input  logic                wvalid,
	output logic                wready,
	input  logic [data_w-1:0]   wdata,
	input  logic [data_w/8-1:0] wstrb,
	output logic                bvalid,
	input  logic                bready,
	output logic [1:0]          bresp,
	input  logic                arvalid,
	output logic                arready,
	input  logic [addr_w-1:0]   araddr,
	output logic                rvalid,
	input  logic                rready,
	output logic [data_w-1:0]   rdata,
	output logic [1:0]          rresp,
	input  logic                draw_valid,
	input  logic [coord_w-1:0]  draw_x,
	input  logic [coord_w-1:0]  draw_y,
	output logic                rgb_valid,
	output logic [color_w-1:0]  red,
	output logic [color_w-1:0]  green,
	output logic [color_w-1:0]  blue
);

	scene_if scene_bus ();

	scene_regs regs (
		.clk     (clk),
		.rst     (rst),
		.awvalid (awvalid),
		.awready (awready),
		.awaddr  (awaddr),
		.wvalid  (wvalid),
		.wready  (wready),
		.wdata   (wdata),
		.wstrb   (wstrb),
		.bvalid  (bvalid),
		.bready  (bready),
		.bresp   (bresp),
		.arvalid (arvalid),
		.arready (arready),
		.araddr  (araddr),
		.rvalid  (rvalid),
		.rready  (rready),
		.rdata   (rdata),
		.rresp   (rresp),
		.scene   (scene_bus.owner)
	);

	scene_render #(
		.car_width (car_w),
		.pad_width (pad_w)
	) render (
		.clk        (clk),
		.rst        (rst),
		.scene      (scene_bus.user),
		.draw_valid (draw_valid),
		.draw_x     (draw_x),
		.draw_y     (draw_y),
		.rgb_valid  (rgb_valid),
		.red        (red),
		.green      (green),
		.blue       (blue)
	);

endmodule

/* verilog/scene_render.sv */
// fixed two-cycle latency, no stall; scene changes apply to pixels entering stage one afterwards
module scene_render
	import frogger_pkg::*;
#(
	parameter int car_width = car_w,
	parameter int pad_width = pad_w
)(
	input  logic               clk,
	input  logic               rst,
	scene_if.user              scene,
	input  logic               draw_valid,
	input  logic [coord_w-1:0] draw_x,
	input  logic [coord_w-1:0] draw_y,
	output logic               rgb_valid,
	output logic [color_w-1:0] red,
	output logic [color_w-1:0] green,
	output logic [color_w-1:0] blue
);

	logic [num_frogs-1:0]               frog_hit;
	logic [num_rows-1:0][row_slots-1:0] car_hit;
	logic [num_rows-1:0][row_slots-1:0] pad_hit;
	bg_class_e                          bg;

	logic                               s1_valid;
	logic [num_frogs-1:0]               s1_frog;
	logic [num_rows-1:0][row_slots-1:0] s1_car;
	logic [num_rows-1:0][row_slots-1:0] s1_pad;
	bg_class_e                          s1_bg;
	logic [rgb_w-1:0]                   pix;

	// ------------------------------
	// stage one, hit tests
	// ------------------------------
	for (genvar f = 0; f < num_frogs; f++)
	begin : frog
		logic [coord_w-1:0] left;
		logic [coord_w-1:0] right;
		logic [coord_w-1:0] top;
		logic [coord_w-1:0] bottom;

		// body box sits inside the 40x40 cell
		assign left   = scene.frog_x[f] + coord_w'(frog_inset_l);
		assign right  = scene.frog_x[f] + coord_w'(frog_w - frog_inset_r);
		assign top    = scene.frog_y[f] + coord_w'(frog_inset_t);
		assign bottom = scene.frog_y[f] + coord_w'(frog_h - frog_inset_b);

		assign frog_hit[f] = draw_x >= left && draw_x <= right &&
			draw_y >= top && draw_y <= bottom;
	end

	for (genvar r = 0; r < num_rows; r++)
	begin : row
		row_hit #(.obj_w(car_width)) car_row (
			.draw_x (draw_x),
			.draw_y (draw_y),
			.xs     (scene.car_x[r]),
			.ys     (scene.car_y[r]),
			.count  (scene.car_count[r]),
			.hit    (car_hit[r])
		);

		row_hit #(.obj_w(pad_width)) pad_row (
			.draw_x (draw_x),
			.draw_y (draw_y),
			.xs     (scene.pad_x[r]),
			.ys     (scene.pad_y[r]),
			.count  (scene.pad_count[r]),
			.hit    (pad_hit[r])
		);
	end

	scenery_map scenery (
		.draw_x (draw_x),
		.draw_y (draw_y),
		.bg     (bg)
	);

	always_ff @(posedge clk)
	begin
		if (rst)
			s1_valid <= 1'b0;
		else
			s1_valid <= draw_valid;
	end

	always_ff @(posedge clk)
	begin
		s1_frog <= frog_hit;
		s1_car  <= car_hit;
		s1_pad  <= pad_hit;
		s1_bg   <= bg;
	end

	// ------------------------------
	// stage two, priority to colour
	// ------------------------------
	always_comb
	begin
		if (|s1_frog)
			pix = frog_rgb;
		else if (|s1_car)
			pix = car_rgb; // flat colour, so row order does not change the result
		else if (|s1_pad)
			pix = pad_rgb;
		else
		begin
			case (s1_bg)
				water:      pix = water_rgb;
				dark_grass: pix = dark_grass_rgb;
				grass:      pix = grass_rgb;
				stripe:     pix = stripe_rgb;
				pavement:   pix = pavement_rgb;
				default:    pix = white_rgb;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			rgb_valid <= 1'b0;
		else
			rgb_valid <= s1_valid;
	end

	always_ff @(posedge clk)
	begin
		{red, green, blue} <= pix;
	end

endmodule

/* verilog/scenery_map.sv */
// fixed background for a 640x480 frame; coordinates outside it still classify
module scenery_map
	import frogger_pkg::*;
(
	input  logic [coord_w-1:0] draw_x,
	input  logic [coord_w-1:0] draw_y,
	output bg_class_e          bg
);

	logic goal_band;
	logic dark_x;
	logic gap_x;
	logic stripe_y;
	logic stripe_x;

	// goal strip at the top: dark grass pockets split by lighter gaps
	assign goal_band = draw_y >= 40 && draw_y <= 79;
	assign dark_x = draw_x <= 119 ||
		(draw_x >= 160 && draw_x <= 279) ||
		(draw_x >= 320 && draw_x <= 479) ||
		(draw_x >= 520 && draw_x <= 679);
	assign gap_x = (draw_x >= 120 && draw_x <= 159) ||
		(draw_x >= 280 && draw_x <= 319) ||
		(draw_x >= 480 && draw_x <= 519);

	// dashed lane markings
	assign stripe_y = (draw_y >= 318 && draw_y <= 322) ||
		(draw_y >= 358 && draw_y <= 362) ||
		(draw_y >= 398 && draw_y <= 402);
	assign stripe_x = draw_x <= 100 ||
		(draw_x >= 200 && draw_x <= 300) ||
		(draw_x >= 400 && draw_x <= 500) ||
		draw_x >= 600;

	always_comb
	begin
		if (draw_y >= 80 && draw_y <= 239)
			bg = water;
		else if (goal_band && dark_x)
			bg = dark_grass;
		else if ((draw_y >= 240 && draw_y <= 279) || draw_y >= 440 || (goal_band && gap_x))
			bg = grass; // median, start bank and goal gaps
		else if (stripe_y && stripe_x)
			bg = stripe;
		else if (draw_y >= 280 && draw_y <= 439)
			bg = pavement;
		else
			bg = white;
	end

endmodule

/* verilog/row_hit.sv */
// box edges inclusive and summed mod 2048; a wrapped slot starts at column 0
module row_hit
	import frogger_pkg::*;
#(
	parameter int obj_w = car_w
)(
	input  logic [coord_w-1:0]                draw_x,
	input  logic [coord_w-1:0]                draw_y,
	input  logic [row_slots-1:0][coord_w-1:0] xs,
	input  logic [row_slots-1:0][coord_w-1:0] ys,
	input  logic [count_w-1:0]                count,
	output logic [row_slots-1:0]              hit
);

	for (genvar s = 0; s < row_slots; s++)
	begin : slot
		logic [coord_w-1:0] left;
		logic [coord_w-1:0] right;
		logic [coord_w-1:0] bottom;
		logic               live;

		// past the right edge, clip to the left side of the screen
		assign left   = (xs[s] >= coord_w'(wrap_x)) ? '0 : xs[s];
		assign right  = xs[s] + coord_w'(obj_w); // truncated, so a wrapped car ends early
		assign bottom = ys[s] + coord_w'(obj_h);
		assign live   = count > count_w'(s);

		assign hit[s] = live &&
			draw_x >= left && draw_x <= right &&
			draw_y >= ys[s] && draw_y <= bottom;
	end

endmodule

/* verilog/scene_regs.sv */
// word addressed, awaddr/araddr bits 1:0 ignored; aw and w must arrive together to be accepted
module scene_regs
	import frogger_pkg::*;
(
	input  logic                clk,
	input  logic                rst,
	input  logic                awvalid,
	output logic                awready,
	input  logic [addr_w-1:0]   awaddr,
	input  logic                wvalid,
	output logic                wready,
	input  logic [data_w-1:0]   wdata,
	input  logic [data_w/8-1:0] wstrb,
	output logic                bvalid,
	input  logic                bready,
	output logic [1:0]          bresp,
	input  logic                arvalid,
	output logic                arready,
	input  logic [addr_w-1:0]   araddr,
	output logic                rvalid,
	input  logic                rready,
	output logic [data_w-1:0]   rdata,
	output logic [1:0]          rresp,
	scene_if.owner              scene
);

	logic        wr_go;
	logic        rd_go;
	scene_word_u wr_old;
	scene_word_u wr_new;

	// ------------------------------
	// address decode
	// ------------------------------
	function automatic logic is_frog(input logic [addr_w-1:0] a);
		return a[7:4] == frog_base[7:4] && a[3:2] < 2'(num_frogs);
	endfunction

	function automatic logic is_count(input logic [addr_w-1:0] a);
		return a[7:2] == count_addr[7:2];
	endfunction

	function automatic logic is_car(input logic [addr_w-1:0] a);
		return a[7:6] == car_base[7:6];
	endfunction

	function automatic logic is_pad(input logic [addr_w-1:0] a);
		return a[7:6] == pad_base[7:6];
	endfunction

	// stored word as seen on the bus, zero when unmapped
	function automatic scene_word_u word_at(input logic [addr_w-1:0] a);
		scene_word_u w;
		w = '0;
		if (is_frog(a))
		begin
			w.pos.x = scene.frog_x[a[3:2]];
			w.pos.y = scene.frog_y[a[3:2]];
		end
		else if (is_count(a))
		begin
			w.cnt.car = scene.car_count;
			w.cnt.pad = scene.pad_count;
		end
		else if (is_car(a))
		begin
			w.pos.x = scene.car_x[a[5:4]][a[3:2]]; // row, slot
			w.pos.y = scene.car_y[a[5:4]][a[3:2]];
		end
		else if (is_pad(a))
		begin
			w.pos.x = scene.pad_x[a[5:4]][a[3:2]];
			w.pos.y = scene.pad_y[a[5:4]][a[3:2]];
		end
		return w;
	endfunction

	// ------------------------------
	// write channel
	// ------------------------------
	assign awready = awvalid && wvalid && !bvalid; // one response in flight at most
	assign wready  = awready;
	assign wr_go   = awready;

	// strobed bytes over the current contents
	always_comb
	begin
		wr_old = word_at(awaddr);
		for (int b = 0; b < data_w / 8; b++)
			wr_new[8*b +: 8] = wstrb[b] ? wdata[8*b +: 8] : wr_old[8*b +: 8];
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			scene.frog_x    <= '0;
			scene.frog_y    <= '0;
			scene.car_x     <= '0;
			scene.car_y     <= '0;
			scene.pad_x     <= '0;
			scene.pad_y     <= '0;
			scene.car_count <= '0;
			scene.pad_count <= '0;
		end
		else if (wr_go)
		begin
			if (is_frog(awaddr))
			begin
				scene.frog_x[awaddr[3:2]] <= wr_new.pos.x;
				scene.frog_y[awaddr[3:2]] <= wr_new.pos.y;
			end
			else if (is_count(awaddr))
			begin
				scene.car_count <= wr_new.cnt.car;
				scene.pad_count <= wr_new.cnt.pad;
			end
			else if (is_car(awaddr))
			begin
				scene.car_x[awaddr[5:4]][awaddr[3:2]] <= wr_new.pos.x;
				scene.car_y[awaddr[5:4]][awaddr[3:2]] <= wr_new.pos.y;
			end
			else if (is_pad(awaddr))
			begin
				scene.pad_x[awaddr[5:4]][awaddr[3:2]] <= wr_new.pos.x;
				scene.pad_y[awaddr[5:4]][awaddr[3:2]] <= wr_new.pos.y;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			bvalid <= 1'b0;
		else if (wr_go)
			bvalid <= 1'b1;
		else if (bready)
			bvalid <= 1'b0;
	end

	always_ff @(posedge clk)
	begin
		if (wr_go)
			bresp <= (is_frog(awaddr) || is_count(awaddr) || is_car(awaddr) || is_pad(awaddr))
				? resp_okay : resp_slverr;
	end

	// ------------------------------
	// read channel
	// ------------------------------
	assign arready = !rvalid;
	assign rd_go   = arvalid && arready;

	always_ff @(posedge clk)
	begin
		if (rst)
			rvalid <= 1'b0;
		else if (rd_go)
			rvalid <= 1'b1;
		else if (rready)
			rvalid <= 1'b0;
	end

	always_ff @(posedge clk)
	begin
		if (rd_go)
		begin
			rdata <= word_at(araddr); // already zero when unmapped
			rresp <= (is_frog(araddr) || is_count(araddr) || is_car(araddr) || is_pad(araddr))
				? resp_okay : resp_slverr;
		end
	end

endmodule

/* verilog/scene_if.sv */
// scene snapshot; every field changes only on an accepted register write
interface scene_if
	import frogger_pkg::*;
();

	logic [num_frogs-1:0][coord_w-1:0] frog_x;
	logic [num_frogs-1:0][coord_w-1:0] frog_y;

	// indexed [row][slot]
	logic [num_rows-1:0][row_slots-1:0][coord_w-1:0] car_x;
	logic [num_rows-1:0][row_slots-1:0][coord_w-1:0] car_y;
	logic [num_rows-1:0][row_slots-1:0][coord_w-1:0] pad_x;
	logic [num_rows-1:0][row_slots-1:0][coord_w-1:0] pad_y;

	logic [num_rows-1:0][count_w-1:0] car_count; // slots at or above count are hidden
	logic [num_rows-1:0][count_w-1:0] pad_count;

	modport owner (
		output frog_x, frog_y,
		output car_x, car_y, pad_x, pad_y,
		output car_count, pad_count
	);

	modport user (
		input frog_x, frog_y,
		input car_x, car_y, pad_x, pad_y,
		input car_count, pad_count
	);

endinterface

/* verilog/frogger_pkg.sv */
// objects drawn flat; all edge sums wrap at 2048, reserved register bits are not stored and read 0
package frogger_pkg;

	// ------------------------------
	// screen and object geometry
	// ------------------------------
	localparam int coord_w   = 11;
	localparam int num_frogs = 3;
	localparam int num_rows  = 4;
	localparam int row_slots = 4;
	localparam int wrap_x    = 680; // x at or past this is drawn from column 0
	localparam int obj_h     = 40;
	localparam int car_w     = 80;
	localparam int pad_w     = 40;
	localparam int frog_w    = 40;
	localparam int frog_h    = 40;
	localparam int frog_inset_l = 7;
	localparam int frog_inset_r = 7;
	localparam int frog_inset_t = 10;
	localparam int frog_inset_b = 5;
	localparam int count_w   = 3;
	localparam int color_w   = 8;
	localparam int rgb_w     = 3 * color_w;

	// {red, green, blue}
	localparam logic [rgb_w-1:0] frog_rgb       = {8'd40, 8'd160, 8'd40};
	localparam logic [rgb_w-1:0] car_rgb        = {8'd200, 8'd0, 8'd0};
	localparam logic [rgb_w-1:0] pad_rgb        = {8'd0, 8'd250, 8'd0};
	localparam logic [rgb_w-1:0] water_rgb      = {8'd0, 8'd200, 8'd255};
	localparam logic [rgb_w-1:0] dark_grass_rgb = {8'd0, 8'd100, 8'd0};
	localparam logic [rgb_w-1:0] grass_rgb      = {8'd0, 8'd200, 8'd0};
	localparam logic [rgb_w-1:0] stripe_rgb     = {8'd255, 8'd204, 8'd0};
	localparam logic [rgb_w-1:0] pavement_rgb   = {8'd69, 8'd69, 8'd69};
	localparam logic [rgb_w-1:0] white_rgb      = {8'd255, 8'd255, 8'd255};

	typedef enum logic [2:0] {
		water,
		dark_grass,
		grass,
		stripe,
		pavement,
		white
	} bg_class_e;

	// ------------------------------
	// register map, byte addresses
	// ------------------------------
	localparam int addr_w = 8;
	localparam int data_w = 32;
	localparam logic [addr_w-1:0] frog_base  = 8'h00; // frog n at 4n
	localparam logic [addr_w-1:0] count_addr = 8'h0C;
	localparam logic [addr_w-1:0] car_base   = 8'h40; // + 16 row + 4 slot
	localparam logic [addr_w-1:0] pad_base   = 8'h80;
	localparam logic [1:0] resp_okay   = 2'b00;
	localparam logic [1:0] resp_slverr = 2'b10;

	// one register word, position or row counts depending on address
	typedef union packed {
		struct packed {
			logic [4:0]         rsvd_hi;
			logic [coord_w-1:0] y;
			logic [4:0]         rsvd_lo;
			logic [coord_w-1:0] x;
		} pos;
		struct packed {
			logic [7:0]                       rsvd;
			logic [num_rows-1:0][count_w-1:0] pad; // row 1 in the low bits
			logic [num_rows-1:0][count_w-1:0] car;
		} cnt;
	} scene_word_u;

endpackage
